// File: common/global_header.svh
`ifndef GLOBAL_HEADER_SVH
`define GLOBAL_HEADER_SVH

// project-wide switches

// 0 keeps the behavioural entry array in btb_ram
// a synthesis flow sets 1 to hide it behind a RAM macro
`define BTB_RAM_COMPILED 0

`endif

// File: common/btb_pkg.sv
package btb_pkg;

  // program counter width
  localparam int PC_W = 32;

  // smallest supported depth, fixes the widest tag
  localparam int MIN_DEPTH = 64;

  // pc bits above the index, two lowest pc bits dropped
  localparam int TAG_W = PC_W - 2 - $clog2(MIN_DEPTH);

  // kind of control transfer stored per entry
  typedef enum logic [1:0] {
    BR_COND = 2'd0,
    BR_JUMP = 2'd1,
    BR_CALL = 2'd2,
    BR_RET  = 2'd3
  } br_type_e;

  // one btb entry
  // deeper tables leave the upper tag bits at zero
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [PC_W-1:0]  target;
    br_type_e         br_type;
  } btb_entry_t;

endpackage

// File: btb/btb_ram.sv
`include "global_header.svh"
`timescale 1ns/100ps

module btb_ram #(
  parameter int DEPTH = 64,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic                clk,
  input  logic [IDX_W-1:0]    rd_addr_i,
  output btb_pkg::btb_entry_t rd_data_o,
  input  logic [IDX_W-1:0]    wr_addr_i,
  input  btb_pkg::btb_entry_t wr_data_i,
  input  logic                wr_en_i
);
  import btb_pkg::*;

  generate
    if (`BTB_RAM_COMPILED == 0)
    begin : g_model
      // entry array, contents undefined until the sweep
      btb_entry_t mem [DEPTH];

      // read port, combinational
      assign rd_data_o = mem[rd_addr_i];

      // write port, one entry per edge
      always_ff @(posedge clk)
      begin
        if (wr_en_i)
          mem[wr_addr_i] <= wr_data_i;
      end
    end
    else
    begin : g_macro
      // hard macro takes the array's place, read data parked
      assign rd_data_o = '0;
    end
  endgenerate

endmodule

// File: btb/btb_lookup.sv
`timescale 1ns/100ps

module btb_lookup #(
  parameter int DEPTH = 64,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     lkp_req_i,
  input  logic [btb_pkg::PC_W-1:0] lkp_pc_i,
  output logic                     lkp_ack_o,
  output logic                     lkp_hit_o,
  output logic [btb_pkg::PC_W-1:0] lkp_target_o,
  output btb_pkg::br_type_e        lkp_type_o,
  input  logic                     init_done_i,
  output logic [IDX_W-1:0]         rd_addr_o,
  input  btb_pkg::btb_entry_t      rd_data_i
);
  import btb_pkg::*;

  typedef enum logic {
    LKP_IDLE,
    LKP_ACK
  } lkp_state_e;

  lkp_state_e       state_q;
  lkp_state_e       state_d;
  logic [TAG_W-1:0] pc_tag;
  logic             hit;
  logic             take;

  // index straight from the pc, word aligned
  assign rd_addr_o = lkp_pc_i[IDX_W+1:2];

  // tag is everything above the index
  // zero extended into the widest tag field
  assign pc_tag = TAG_W'(lkp_pc_i >> (IDX_W + 2));

  // hit needs a valid entry with a matching tag
  assign hit = rd_data_i.valid && (rd_data_i.tag == pc_tag);

  // new request accepted only once the sweep is over
  assign take = (state_q == LKP_IDLE) && lkp_req_i && init_done_i;

  // four-phase sequencing
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      LKP_IDLE:
      begin
        if (take)
          state_d = LKP_ACK;
      end
      LKP_ACK:
      begin
        // ack held as long as req stays high
        if (!lkp_req_i)
          state_d = LKP_IDLE;
      end
      default:
        state_d = LKP_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
      state_q <= LKP_IDLE;
    else
      state_q <= state_d;
  end

  // ack is the ack state itself
  assign lkp_ack_o = (state_q == LKP_ACK);

  // results captured with ack, frozen until the next request
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      lkp_hit_o    <= hit;
      lkp_target_o <= rd_data_i.target;
      lkp_type_o   <= rd_data_i.br_type;
    end
  end

endmodule

// File: btb/btb_update.sv
`timescale 1ns/100ps

module btb_update #(
  parameter int DEPTH = 64,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     upd_req_i,
  input  logic [btb_pkg::PC_W-1:0] upd_pc_i,
  input  logic [btb_pkg::PC_W-1:0] upd_target_i,
  input  btb_pkg::br_type_e        upd_type_i,
  input  logic                     upd_inval_i,
  output logic                     upd_ack_o,
  output logic                     init_done_o,
  output logic                     wr_en_o,
  output logic [IDX_W-1:0]         wr_addr_o,
  output btb_pkg::btb_entry_t      wr_data_o
);
  import btb_pkg::*;

  typedef enum logic [1:0] {
    UPD_SWEEP,
    UPD_IDLE,
    UPD_ACK
  } upd_state_e;

  upd_state_e       state_q;
  upd_state_e       state_d;
  logic [IDX_W-1:0] sweep_cnt_q;
  logic             sweep_last;
  logic             upd_take;
  btb_entry_t       upd_entry;

  // last index of the sweep
  assign sweep_last = (sweep_cnt_q == IDX_W'(DEPTH - 1));

  // a request in idle writes on this very edge
  assign upd_take = (state_q == UPD_IDLE) && upd_req_i;

  // entry from the resolved branch
  // invalidate keeps the slot but clears valid
  always_comb
  begin
    upd_entry.valid   = ~upd_inval_i;
    upd_entry.tag     = TAG_W'(upd_pc_i >> (IDX_W + 2));
    upd_entry.target  = upd_target_i;
    upd_entry.br_type = upd_type_i;
  end

  // single owner of the ram write port
  always_comb
  begin
    if (state_q == UPD_SWEEP)
    begin
      // one invalid entry per cycle
      wr_en_o   = 1'b1;
      wr_addr_o = sweep_cnt_q;
      wr_data_o = '0;
    end
    else
    begin
      wr_en_o   = upd_take;
      wr_addr_o = upd_pc_i[IDX_W+1:2];
      wr_data_o = upd_entry;
    end
  end

  // sweep, then four-phase service
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      UPD_SWEEP:
      begin
        if (sweep_last)
          state_d = UPD_IDLE;
      end
      UPD_IDLE:
      begin
        if (upd_req_i)
          state_d = UPD_ACK;
      end
      UPD_ACK:
      begin
        // no second write until req has dropped
        if (!upd_req_i)
          state_d = UPD_IDLE;
      end
      default:
        state_d = UPD_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      state_q     <= UPD_SWEEP;
      sweep_cnt_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == UPD_SWEEP)
        sweep_cnt_q <= sweep_cnt_q + 1'b1;
    end
  end

  // table usable once the sweep has left
  assign init_done_o = (state_q != UPD_SWEEP);
  assign upd_ack_o   = (state_q == UPD_ACK);

endmodule

// File: hdl/btb_top.sv
`timescale 1ns/100ps

module btb_top #(
  parameter int DEPTH = 64
) (
  input  logic                     clk,
  input  logic                     rst_i,
  // lookup channel from fetch
  input  logic                     lkp_req_i,
  input  logic [btb_pkg::PC_W-1:0] lkp_pc_i,
  output logic                     lkp_ack_o,
  output logic                     lkp_hit_o,
  output logic [btb_pkg::PC_W-1:0] lkp_target_o,
  output btb_pkg::br_type_e        lkp_type_o,
  // update channel from branch resolution
  input  logic                     upd_req_i,
  input  logic [btb_pkg::PC_W-1:0] upd_pc_i,
  input  logic [btb_pkg::PC_W-1:0] upd_target_i,
  input  btb_pkg::br_type_e        upd_type_i,
  input  logic                     upd_inval_i,
  output logic                     upd_ack_o
);
  import btb_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  // ram read side, owned by lookup
  logic [IDX_W-1:0] rd_addr;
  btb_entry_t       rd_data;

  // ram write side, owned by update
  logic             wr_en;
  logic [IDX_W-1:0] wr_addr;
  btb_entry_t       wr_data;

  // sweep finished
  logic             init_done;

  btb_ram #(
    .DEPTH (DEPTH)
  ) ram_i (
    .clk       (clk),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .wr_en_i   (wr_en)
  );

  btb_lookup #(
    .DEPTH (DEPTH)
  ) lookup_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .lkp_req_i    (lkp_req_i),
    .lkp_pc_i     (lkp_pc_i),
    .lkp_ack_o    (lkp_ack_o),
    .lkp_hit_o    (lkp_hit_o),
    .lkp_target_o (lkp_target_o),
    .lkp_type_o   (lkp_type_o),
    .init_done_i  (init_done),
    .rd_addr_o    (rd_addr),
    .rd_data_i    (rd_data)
  );

  btb_update #(
    .DEPTH (DEPTH)
  ) update_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .upd_req_i    (upd_req_i),
    .upd_pc_i     (upd_pc_i),
    .upd_target_i (upd_target_i),
    .upd_type_i   (upd_type_i),
    .upd_inval_i  (upd_inval_i),
    .upd_ack_o    (upd_ack_o),
    .init_done_o  (init_done),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data)
  );

endmodule

// File: dv/btb_tb.sv
`timescale 1ns/100ps

module btb_tb;
  import btb_pkg::*;

  localparam int DEPTH = 64;
  localparam int IDX_W = $clog2(DEPTH);
  localparam int NUM_TXN = 240;
  localparam int ACK_LIMIT = 100;
  // reset, sweep, then ten cycles per transaction
  localparam int WATCHDOG_CYCLES = 2 + DEPTH + NUM_TXN * 10;

  logic            clk;
  logic            rst_i;
  logic            lkp_req_i;
  logic [PC_W-1:0] lkp_pc_i;
  logic            lkp_ack_o;
  logic            lkp_hit_o;
  logic [PC_W-1:0] lkp_target_o;
  br_type_e        lkp_type_o;
  logic            upd_req_i;
  logic [PC_W-1:0] upd_pc_i;
  logic [PC_W-1:0] upd_target_i;
  br_type_e        upd_type_i;
  logic            upd_inval_i;
  logic            upd_ack_o;

  // reference table, one slot per pc index
  logic            ref_valid [DEPTH];
  logic [PC_W-1:0] ref_tag [DEPTH];
  logic [PC_W-1:0] ref_target [DEPTH];
  br_type_e        ref_type [DEPTH];
  logic [31:0]     rng_state;

  btb_top #(
    .DEPTH (DEPTH)
  ) dut_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .lkp_req_i    (lkp_req_i),
    .lkp_pc_i     (lkp_pc_i),
    .lkp_ack_o    (lkp_ack_o),
    .lkp_hit_o    (lkp_hit_o),
    .lkp_target_o (lkp_target_o),
    .lkp_type_o   (lkp_type_o),
    .upd_req_i    (upd_req_i),
    .upd_pc_i     (upd_pc_i),
    .upd_target_i (upd_target_i),
    .upd_type_i   (upd_type_i),
    .upd_inval_i  (upd_inval_i),
    .upd_ack_o    (upd_ack_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // index sits above the two ignored bits, tag above the index
  function automatic int pc_index(input logic [PC_W-1:0] pc);
    return int'(pc[IDX_W+1:2]);
  endfunction

  function automatic logic [PC_W-1:0] pc_tag(input logic [PC_W-1:0] pc);
    return pc >> (IDX_W + 2);
  endfunction

  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("Error: %s expected %0h actual %0h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // waits edge by edge for ack to reach a level, counts the edges
  task automatic wait_ack(input string name, input bit lkp, input logic level, output int cycles);
    logic ack;
    cycles = 0;
    ack = ~level;
    while (ack !== level && cycles < ACK_LIMIT)
    begin
      @(posedge clk);
      @(negedge clk);
      cycles++;
      ack = lkp ? lkp_ack_o : upd_ack_o;
    end
    if (ack !== level)
    begin
      $display("%s: ack never reached %0b within %0d cycles", name, level, ACK_LIMIT);
      $display("TEST FAIL");
      $fatal(1, "handshake stalled");
    end
  endtask

  task automatic model_write(input logic [PC_W-1:0] pc, input logic [PC_W-1:0] target,
                             input br_type_e typ, input logic inval);
    int idx;
    idx = pc_index(pc);
    ref_valid[idx]  = ~inval;
    ref_tag[idx]    = pc_tag(pc);
    ref_target[idx] = target;
    ref_type[idx]   = typ;
  endtask

  // full four-phase lookup, result checked against the table
  task automatic do_lookup(input string name, input logic [PC_W-1:0] pc);
    int   n;
    int   idx;
    logic exp_hit;
    idx = pc_index(pc);
    exp_hit = ref_valid[idx] && (ref_tag[idx] == pc_tag(pc));
    lkp_pc_i  = pc;
    lkp_req_i = 1'b1;
    wait_ack(name, 1'b1, 1'b1, n);
    check_equal({name, " ack latency"}, 1, n);
    check_equal({name, " hit"}, exp_hit, lkp_hit_o);
    if (exp_hit)
    begin
      check_equal({name, " target"}, ref_target[idx], lkp_target_o);
      check_equal({name, " type"}, ref_type[idx], lkp_type_o);
    end
    lkp_req_i = 1'b0;
    wait_ack(name, 1'b1, 1'b0, n);
    check_equal({name, " ack release"}, 1, n);
  endtask

  task automatic do_update(input string name, input logic [PC_W-1:0] pc,
                           input logic [PC_W-1:0] target, input br_type_e typ,
                           input logic inval);
    int n;
    upd_pc_i     = pc;
    upd_target_i = target;
    upd_type_i   = typ;
    upd_inval_i  = inval;
    upd_req_i    = 1'b1;
    wait_ack(name, 1'b0, 1'b1, n);
    check_equal({name, " ack latency"}, 1, n);
    model_write(pc, target, typ, inval);
    upd_req_i = 1'b0;
    wait_ack(name, 1'b0, 1'b0, n);
    check_equal({name, " ack release"}, 1, n);
  endtask

  // entered on the falling edge that releases reset
  // both channels request all through the sweep
  task automatic test_reset_sweep();
    int n;
    lkp_pc_i     = 32'h0000_1234;
    lkp_req_i    = 1'b1;
    upd_pc_i     = 32'h0000_5678;
    upd_target_i = 32'h0bad_0000;
    upd_type_i   = BR_RET;
    upd_inval_i  = 1'b1;
    upd_req_i    = 1'b1;
    for (int i = 0; i < DEPTH; i++)
    begin
      @(posedge clk);
      @(negedge clk);
      check_equal("reset_sweep lookup ack early", 0, lkp_ack_o);
      check_equal("reset_sweep update ack early", 0, upd_ack_o);
    end
    @(posedge clk);
    @(negedge clk);
    check_equal("reset_sweep first ack", 1, lkp_ack_o);
    check_equal("reset_sweep first hit", 0, lkp_hit_o);
    check_equal("reset_sweep first update ack", 1, upd_ack_o);
    model_write(32'h0000_5678, 32'h0bad_0000, BR_RET, 1'b1);
    lkp_req_i = 1'b0;
    upd_req_i = 1'b0;
    wait_ack("reset_sweep", 1'b1, 1'b0, n);
    check_equal("reset_sweep lookup release", 1, n);
    check_equal("reset_sweep update release", 0, upd_ack_o);
    do_lookup("reset_sweep miss a", 32'hdead_beec);
    do_lookup("reset_sweep miss b", 32'h0040_00fc);
    do_lookup("reset_sweep miss c", 32'h8000_0000);
  endtask

  task automatic test_write_hit();
    logic [PC_W-1:0] pc;
    for (int t = 0; t < 4; t++)
    begin
      pc = 32'h8000_0100 + PC_W'(t * 4);
      do_update("write_hit update", pc, 32'h1000_0000 + PC_W'(t * 'h40), br_type_e'(t), 1'b0);
      do_lookup("write_hit lookup", pc);
    end
  endtask

  // same index, tags one apart
  task automatic test_alias();
    logic [PC_W-1:0] pc_a;
    logic [PC_W-1:0] pc_b;
    pc_a = 32'h0001_0040;
    pc_b = pc_a + PC_W'(DEPTH * 4);
    do_update("alias first", pc_a, 32'h2000_0000, BR_JUMP, 1'b0);
    do_lookup("alias first hit", pc_a);
    do_lookup("alias second miss", pc_b);
    do_update("alias second", pc_b, 32'h2100_0000, BR_COND, 1'b0);
    do_lookup("alias first evicted", pc_a);
    do_lookup("alias second hit", pc_b);
  endtask

  task automatic test_invalidate();
    logic [PC_W-1:0] pc;
    pc = 32'h0002_0a08;
    do_update("invalidate fill", pc, 32'h3000_0000, BR_CALL, 1'b0);
    do_lookup("invalidate before", pc);
    do_update("invalidate drop", pc, 32'h0, BR_COND, 1'b1);
    do_lookup("invalidate after", pc);
  endtask

  task automatic test_handshake();
    logic [PC_W-1:0] pc;
    int              n;
    pc = 32'h0003_0c10;
    do_update("handshake fill", pc, 32'h4444_0000, BR_CALL, 1'b0);
    // lookup held high while the entry is rewritten underneath
    lkp_pc_i  = pc;
    lkp_req_i = 1'b1;
    wait_ack("handshake lookup", 1'b1, 1'b1, n);
    repeat (3)
    begin
      @(posedge clk);
      @(negedge clk);
      check_equal("handshake lookup ack held", 1, lkp_ack_o);
    end
    do_update("handshake rewrite", pc, 32'h5555_0000, BR_JUMP, 1'b0);
    check_equal("handshake lookup still acked", 1, lkp_ack_o);
    check_equal("handshake held hit", 1, lkp_hit_o);
    check_equal("handshake held target", 32'h4444_0000, lkp_target_o);
    check_equal("handshake held type", BR_CALL, lkp_type_o);
    lkp_req_i = 1'b0;
    wait_ack("handshake lookup", 1'b1, 1'b0, n);
    check_equal("handshake lookup release", 1, n);
    // held update, data moved under it must not be written
    upd_pc_i     = pc;
    upd_target_i = 32'h6666_0000;
    upd_type_i   = BR_RET;
    upd_inval_i  = 1'b0;
    upd_req_i    = 1'b1;
    wait_ack("handshake update", 1'b0, 1'b1, n);
    check_equal("handshake update latency", 1, n);
    model_write(pc, 32'h6666_0000, BR_RET, 1'b0);
    upd_target_i = 32'h7777_0000;
    repeat (4)
    begin
      @(posedge clk);
      @(negedge clk);
      check_equal("handshake update ack held", 1, upd_ack_o);
    end
    upd_req_i = 1'b0;
    wait_ack("handshake update", 1'b0, 1'b0, n);
    check_equal("handshake update release", 1, n);
    do_lookup("handshake single write", pc);
  endtask

  task automatic test_random();
    logic [PC_W-1:0] pool [8];
    logic [PC_W-1:0] pc;
    logic [31:0]     r;
    // four indices with two tags each
    for (int i = 0; i < 8; i++)
      pool[i] = PC_W'((i / 4 + 1) << (IDX_W + 2)) | PC_W'(((i % 4) * 5) << 2);
    for (int i = 0; i < 200; i++)
    begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      pc = pool[r[2:0]] | PC_W'(r[17:16]);
      if (r[8])
      begin
        rng_state = xorshift32(rng_state);
        do_update("random update", pc, rng_state, br_type_e'(r[5:4]), r[12:10] == 3'd0);
      end
      else
        do_lookup("random lookup", pc);
    end
  endtask

  initial
  begin
    rst_i        = 1'b1;
    lkp_req_i    = 1'b0;
    lkp_pc_i     = '0;
    upd_req_i    = 1'b0;
    upd_pc_i     = '0;
    upd_target_i = '0;
    upd_type_i   = BR_COND;
    upd_inval_i  = 1'b0;
    rng_state    = 32'hb01ebf22;
    // sweep leaves every slot invalid
    for (int k = 0; k < DEPTH; k++)
      model_write(PC_W'(k << 2), '0, BR_COND, 1'b1);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    test_reset_sweep();
    test_write_hit();
    test_alias();
    test_invalidate();
    test_handshake();
    test_random();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: compile.f
+incdir+common
common/btb_pkg.sv
btb/btb_ram.sv
btb/btb_lookup.sv
btb/btb_update.sv
hdl/btb_top.sv
dv/btb_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module btb_tb -Mdir obj_dir -f compile.f
	./obj_dir/Vbtb_tb 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
